// File: axi_wr_demux.f
+incdir+verilog
verilog/axi_wr_demux_pkg.sv
verilog/axi_wr_demux_ifs.sv
verilog/aw_lock_fsm.sv
verilog/w_open_counter.sv
verilog/id_table.sv
verilog/w_router.sv
verilog/b_arbiter.sv
verilog/axi_wr_demux.sv
sim/tb_clock.sv
sim/axi_wr_demux_properties.sv
sim/axi_wr_demux_tb.sv

// File: sim/axi_wr_demux_tb.sv
// write demux testbench
`timescale 1ns/1ps

module axi_wr_demux_tb;
  // worst case cycles per test and a timeout of twice their sum
  localparam int RAND_TXNS = 24;
  localparam int RAND_MAX  = RAND_TXNS * 60;
  localparam int STALL_MAX = 300;
  localparam int ARB_MAX   = 300;
  localparam int TIMEOUT   = 2 * (RAND_MAX + STALL_MAX + ARB_MAX);

  logic clk_i, reset_i;
  logic aw_valid_i, aw_ready_o, w_valid_i, w_ready_o, w_last_i, b_valid_o, b_ready_i;
  logic [3:0] aw_id_i, b_id_o, mst_aw_id_o;
  logic [1:0] aw_select_i, b_resp_o;
  logic [31:0] w_data_i, mst_w_data_o;
  logic mst_w_last_o;
  logic [3:0] mst_aw_valid_o, mst_aw_ready_i, mst_w_valid_o, mst_w_ready_i;
  logic [3:0] mst_b_valid_i, mst_b_ready_o;
  logic [3:0][3:0] mst_b_id_i;
  logic [3:0][1:0] mst_b_resp_i;

  // master models and reference state
  logic [3:0] aw_q [4][$];
  logic [3:0] b_q [4][$];
  logic [1:0] exp_port_q [$];
  int exp_len_q [$];
  logic [31:0] exp_data_q [$];
  int out_cnt [16];
  logic [1:0] out_port [16];
  logic [3:0] hold, b_taken;
  logic fast_b;
  int pend_len, beat, aw_count, b_count, err_count, check_count, cycles;
  logic [15:0] lfsr_q = 16'd19;

  tb_clock u_clk (.clk_o(clk_i), .reset_o(reset_i));

  axi_wr_demux uut (.*);

  // 16-bit Fibonacci LFSR stepped once per bit
  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] r;
    logic fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  // --------------------
  // master port drivers
  // --------------------
  always @(negedge clk_i) begin
    if (!reset_i) begin
      mst_aw_ready_i = 4'(next_bits(4));
      mst_w_ready_i  = 4'(next_bits(4));
      b_ready_i      = 1'(next_bits(1));
      for (int p = 0; p < 4; p++) begin
        if (b_taken[p]) begin
          mst_b_valid_i[p] = 1'b0;
          b_taken[p] = 1'b0;
        end
        // next B once its burst is done unless the port is held
        if (!mst_b_valid_i[p] && b_q[p].size() > 0 && !hold[p] &&
            (fast_b || next_bits(1) != 0)) begin
          mst_b_valid_i[p] = 1'b1;
          mst_b_id_i[p]    = b_q[p][0];
          mst_b_resp_i[p]  = 2'(p);
        end
      end
    end
  end

  // --------------------
  // monitor and reference checks
  // --------------------
  always @(posedge clk_i) begin
    if (!reset_i) begin
      for (int p = 0; p < 4; p++) begin
        // an ID in flight elsewhere must not reach a second port
        if (mst_aw_valid_o[p]) begin
          check_count++;
          assert (out_cnt[mst_aw_id_o] == 0 || out_port[mst_aw_id_o] == 2'(p))
            else begin
              $display("AW with ID %h reached port %0d while it was in flight to port %0d",
                       mst_aw_id_o, p, out_port[mst_aw_id_o]);
              err_count++;
            end
        end
        if (mst_aw_valid_o[p] && mst_aw_ready_i[p]) begin
          aw_q[p].push_back(mst_aw_id_o);
          exp_port_q.push_back(2'(p));
          exp_len_q.push_back(pend_len);
          out_cnt[mst_aw_id_o]++;
          out_port[mst_aw_id_o] = 2'(p);
          aw_count++;
        end
        if (mst_w_valid_o[p] && mst_w_ready_i[p] && mst_w_last_o) begin
          b_q[p].push_back(aw_q[p].pop_front());
        end
        if (mst_b_valid_i[p] && mst_b_ready_o[p]) begin
          // the slave port carries the ID this port returned
          check_count++;
          assert (b_id_o == b_q[p][0])
            else begin
              $display("ERROR b_id_o got %h expected %h", b_id_o, b_q[p][0]);
              err_count++;
            end
          void'(b_q[p].pop_front());
          b_taken[p] = 1'b1;
        end
      end
      if (w_valid_i && w_ready_o) begin
        check_count++;
        assert (exp_port_q.size() > 0)
          else begin
            $display("W beat accepted with no open AW");
            err_count++;
          end
        if (exp_port_q.size() > 0) begin
          assert (mst_w_valid_o == (4'b1 << exp_port_q[0]))
            else begin
              $display("ERROR mst_w_valid_o got %h expected %h",
                       mst_w_valid_o, 4'b1 << exp_port_q[0]);
              err_count++;
            end
          assert (mst_w_data_o == exp_data_q[0])
            else begin
              $display("ERROR mst_w_data_o got %h expected %h",
                       mst_w_data_o, exp_data_q[0]);
              err_count++;
            end
          assert (mst_w_last_o == (beat == exp_len_q[0] - 1))
            else begin
              $display("ERROR mst_w_last_o got %h expected %h",
                       mst_w_last_o, beat == exp_len_q[0] - 1);
              err_count++;
            end
          void'(exp_data_q.pop_front());
          beat++;
          if (beat == exp_len_q[0]) begin
            void'(exp_port_q.pop_front());
            void'(exp_len_q.pop_front());
            beat = 0;
          end
        end
      end
      if (b_valid_o && b_ready_i) begin
        out_cnt[b_id_o]--;
        b_count++;
      end
    end
  end

  // watchdog
  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("run stopped after %0d cycles with traffic still pending", cycles);
      $display("Verification failed");
      $finish;
    end
  end

  // one AW and its W burst that ends at the edge of the last W handshake
  task automatic send_txn(input logic [3:0] id, input logic [1:0] sel, input int len);
    logic [31:0] data [4];
    for (int i = 0; i < 4; i++) begin
      data[i] = next_bits(32);
    end
    @(negedge clk_i);
    w_valid_i = 1'b0;
    aw_valid_i = 1'b1;
    aw_id_i = id;
    aw_select_i = sel;
    pend_len = len;
    do @(posedge clk_i); while (!aw_ready_o);
    for (int b = 0; b < len; b++) begin
      @(negedge clk_i);
      aw_valid_i = 1'b0;
      w_valid_i = 1'b1;
      w_data_i = data[b];
      w_last_i = (b == len - 1);
      exp_data_q.push_back(data[b]);
      do @(posedge clk_i); while (!w_ready_o);
    end
  endtask

  task automatic drain(input string name);
    @(negedge clk_i);
    w_valid_i = 1'b0;
    while (aw_count != b_count) @(negedge clk_i);
    @(posedge clk_i);
    $display("test %s done, %0d errors so far", name, err_count);
  endtask

  initial begin
    int aw_before;
    aw_valid_i = 1'b0;
    aw_id_i = '0;
    aw_select_i = '0;
    w_valid_i = 1'b0;
    w_data_i = '0;
    w_last_i = 1'b0;
    b_ready_i = 1'b0;
    mst_aw_ready_i = '0;
    mst_w_ready_i = '0;
    mst_b_valid_i = '0;
    mst_b_id_i = '0;
    mst_b_resp_i = '0;
    hold = '0;
    b_taken = '0;
    fast_b = 1'b0;
    pend_len = 0;
    beat = 0;
    aw_count = 0;
    b_count = 0;
    err_count = 0;
    check_count = 0;
    cycles = 0;
    foreach (out_cnt[i]) out_cnt[i] = 0;
    do @(posedge clk_i); while (reset_i);

    // random traffic over all ports
    for (int t = 0; t < RAND_TXNS; t++) begin
      send_txn(4'(next_bits(4)), 2'(next_bits(2)), 1 + int'(next_bits(2)));
    end
    drain("random_traffic");

    // same ID to a second port waits for the first port's B
    hold[0] = 1'b1;
    send_txn(4'h5, 2'd0, 2);
    aw_before = aw_count;
    fork
      send_txn(4'h5, 2'd1, 1);
      begin
        repeat (12) @(negedge clk_i);
        check_count++;
        assert (aw_count == aw_before)
          else begin
            $display("AW accepted while its ID was still in flight to another port");
            err_count++;
          end
        @(posedge clk_i);
        hold[0] = 1'b0;
      end
    join
    drain("id_stall");

    // two ports with B waiting at once
    hold = 4'b0110;
    fast_b = 1'b1;
    send_txn(4'h1, 2'd1, 1);
    send_txn(4'h2, 2'd2, 1);
    send_txn(4'h1, 2'd1, 2);
    send_txn(4'h2, 2'd2, 1);
    @(posedge clk_i);
    hold = 4'b0000;
    drain("b_arbitration");

    $display("tests 3, checks %0d, tb errors %0d, assertion failures %0d",
             check_count, err_count, uut.props.fail_count);
    if (err_count == 0 && uut.props.fail_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: sim/axi_wr_demux_properties.sv
// demux protocol assertions
`timescale 1ns/1ps

module axi_wr_demux_properties (
  input logic                        clk_i,
  input logic                        reset_i,
  input axi_wr_demux_pkg::port_sel_t aw_select_i,
  input axi_wr_demux_pkg::axi_id_t   aw_id_i,
  input axi_wr_demux_pkg::port_vec_t mst_aw_valid_o,
  input axi_wr_demux_pkg::port_vec_t mst_aw_ready_i,
  input axi_wr_demux_pkg::axi_id_t   mst_aw_id_o,
  input axi_wr_demux_pkg::port_vec_t mst_b_valid_i,
  input axi_wr_demux_pkg::port_vec_t mst_b_ready_o,
  input logic                        b_valid_o,
  input logic                        b_ready_i,
  input axi_wr_demux_pkg::axi_id_t   b_id_o,
  input axi_wr_demux_pkg::resp_t     b_resp_o
);
  import axi_wr_demux_pkg::*;

  int unsigned fail_count = 0;
  logic        b_wait_q;
  logic        last_vld_q;
  port_sel_t   last_q;
  logic        new_grant;
  port_vec_t   others;

  // --------------------
  // B grant tracking
  // --------------------
  // a B left waiting keeps its grant, so a new choice only follows a handshake or idle
  always @(posedge clk_i) begin
    if (reset_i) begin
      b_wait_q   <= 1'b0;
      last_vld_q <= 1'b0;
      last_q     <= '0;
    end else begin
      b_wait_q <= b_valid_o && !b_ready_i;
      if (b_valid_o && b_ready_i) begin
        // response code names the source port
        last_q     <= b_resp_o;
        last_vld_q <= 1'b1;
      end
    end
  end

  assign new_grant = b_valid_o && !b_wait_q;
  assign others    = mst_b_valid_i & ~(port_vec_t'(1) << last_q);

  // AW routing
  aw_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(mst_aw_valid_o))
    else begin $error("AW valid not one-hot"); fail_count++; end
  aw_port: assert property (@(posedge clk_i) disable iff (reset_i)
    (|mst_aw_valid_o) |-> (mst_aw_valid_o == (port_vec_t'(1) << aw_select_i)))
    else begin $error("AW valid on wrong port"); fail_count++; end
  aw_id: assert property (@(posedge clk_i) disable iff (reset_i)
    mst_aw_id_o == aw_id_i)
    else begin $error("AW ID not passed through"); fail_count++; end

  // valid stability under back-pressure
  aw_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    ((|mst_aw_valid_o) && !(|(mst_aw_valid_o & mst_aw_ready_i))) |=>
    ((mst_aw_valid_o == $past(mst_aw_valid_o)) && (mst_aw_id_o == $past(mst_aw_id_o))))
    else begin $error("AW valid or ID dropped before handshake"); fail_count++; end
  b_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    (b_valid_o && !b_ready_i) |=> (b_valid_o && $stable(b_id_o) && $stable(b_resp_o)))
    else begin $error("B valid or payload dropped before handshake"); fail_count++; end

  // B arbitration
  b_source: assert property (@(posedge clk_i) disable iff (reset_i)
    (b_valid_o && b_ready_i) |-> (mst_b_ready_o == (port_vec_t'(1) << b_resp_o)))
    else begin $error("B taken from a port other than its response"); fail_count++; end
  b_rotate: assert property (@(posedge clk_i) disable iff (reset_i)
    (new_grant && last_vld_q && (|others)) |-> (b_resp_o != last_q))
    else begin $error("B winner granted again while another port waits"); fail_count++; end

endmodule

bind axi_wr_demux axi_wr_demux_properties props (.*);

// File: sim/tb_clock.sv
// testbench clock and reset
`timescale 1ns/1ps

module tb_clock (
  output logic clk_o,
  output logic reset_o
);

  // 10 ns period
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // reset held for 8 cycles and released on a falling edge
  initial begin
    reset_o = 1'b1;
    repeat (8) @(posedge clk_o);
    @(negedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

// File: verilog/axi_wr_demux.sv
// write channel AXI demux
`timescale 1ns/1ps
`include "axi_wr_demux_macros.svh"

module axi_wr_demux (
  input  logic                                              clk_i,
  input  logic                                              reset_i,
  // slave AW
  input  logic                                              aw_valid_i,
  output logic                                              aw_ready_o,
  input  axi_wr_demux_pkg::axi_id_t                         aw_id_i,
  input  axi_wr_demux_pkg::port_sel_t                       aw_select_i,
  // slave W
  input  logic                                              w_valid_i,
  output logic                                              w_ready_o,
  input  axi_wr_demux_pkg::data_t                           w_data_i,
  input  logic                                              w_last_i,
  // slave B
  output logic                                              b_valid_o,
  input  logic                                              b_ready_i,
  output axi_wr_demux_pkg::axi_id_t                         b_id_o,
  output axi_wr_demux_pkg::resp_t                           b_resp_o,
  // master AW, ID shared by all ports
  output axi_wr_demux_pkg::port_vec_t                       mst_aw_valid_o,
  input  axi_wr_demux_pkg::port_vec_t                       mst_aw_ready_i,
  output axi_wr_demux_pkg::axi_id_t                         mst_aw_id_o,
  // master W, data and last shared
  output axi_wr_demux_pkg::port_vec_t                       mst_w_valid_o,
  input  axi_wr_demux_pkg::port_vec_t                       mst_w_ready_i,
  output axi_wr_demux_pkg::data_t                           mst_w_data_o,
  output logic                                              mst_w_last_o,
  // master B
  input  axi_wr_demux_pkg::port_vec_t                       mst_b_valid_i,
  output axi_wr_demux_pkg::port_vec_t                       mst_b_ready_o,
  input  axi_wr_demux_pkg::axi_id_t [`DEMUX_NUM_PORTS-1:0]  mst_b_id_i,
  input  axi_wr_demux_pkg::resp_t   [`DEMUX_NUM_PORTS-1:0]  mst_b_resp_i
);
  import axi_wr_demux_pkg::*;

  logic aw_fwd, aw_hs, b_pop;

  id_track_if id_trk ();
  w_route_if  w_rt ();

  // --------------------
  // AW
  // --------------------
  // only the selected port sees the forwarded valid
  assign mst_aw_valid_o = aw_fwd ? (port_vec_t'(1) << aw_select_i) : '0;
  assign aw_hs          = aw_fwd & mst_aw_ready_i[aw_select_i];
  assign aw_ready_o     = aw_hs;
  assign mst_aw_id_o    = aw_id_i;

  aw_lock_fsm u_aw_fsm (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .aw_valid_i  (aw_valid_i),
    .aw_id_i     (aw_id_i),
    .aw_select_i (aw_select_i),
    .aw_fwd_o    (aw_fwd),
    .aw_hs_i     (aw_hs),
    .id_trk      (id_trk),
    .w_rt        (w_rt)
  );

  // ID is released once its B leaves on the slave port
  assign b_pop = b_valid_o & b_ready_i;

  id_table u_id_table (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .aw_select_i (aw_select_i),
    .pop_i       (b_pop),
    .pop_id_i    (b_id_o),
    .id_trk      (id_trk)
  );

  // --------------------
  // W
  // --------------------
  assign mst_w_data_o = w_data_i;
  assign mst_w_last_o = w_last_i;

  w_open_counter u_w_cnt (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .aw_select_i (aw_select_i),
    .w_rt        (w_rt)
  );

  w_router u_w_router (
    .w_valid_i     (w_valid_i),
    .w_last_i      (w_last_i),
    .mst_w_ready_i (mst_w_ready_i),
    .w_ready_o     (w_ready_o),
    .mst_w_valid_o (mst_w_valid_o),
    .w_rt          (w_rt)
  );

  // --------------------
  // B
  // --------------------
  b_arbiter u_b_arb (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .mst_b_valid_i (mst_b_valid_i),
    .mst_b_id_i    (mst_b_id_i),
    .mst_b_resp_i  (mst_b_resp_i),
    .b_ready_i     (b_ready_i),
    .mst_b_ready_o (mst_b_ready_o),
    .b_valid_o     (b_valid_o),
    .b_id_o        (b_id_o),
    .b_resp_o      (b_resp_o)
  );

endmodule

// File: verilog/b_arbiter.sv
// B response arbiter
`timescale 1ns/1ps
`include "axi_wr_demux_macros.svh"

module b_arbiter (
  input  logic                                              clk_i,
  input  logic                                              reset_i,
  input  axi_wr_demux_pkg::port_vec_t                       mst_b_valid_i,
  input  axi_wr_demux_pkg::axi_id_t [`DEMUX_NUM_PORTS-1:0]  mst_b_id_i,
  input  axi_wr_demux_pkg::resp_t   [`DEMUX_NUM_PORTS-1:0]  mst_b_resp_i,
  input  logic                                              b_ready_i,
  output axi_wr_demux_pkg::port_vec_t                       mst_b_ready_o,
  output logic                                              b_valid_o,
  output axi_wr_demux_pkg::axi_id_t                         b_id_o,
  output axi_wr_demux_pkg::resp_t                           b_resp_o
);
  import axi_wr_demux_pkg::*;

  port_sel_t prio_q;
  port_sel_t lock_idx_q;
  logic      lock_q;
  port_sel_t pick, gnt_idx;
  logic      b_hs;

  // --------------------
  // round-robin pick
  // --------------------
  // scan downwards so the nearest valid at or after prio_q wins
  always_comb begin
    port_sel_t idx;
    pick = prio_q;
    for (int k = `DEMUX_NUM_PORTS - 1; k >= 0; k--) begin
      idx = prio_q + port_sel_t'(k);
      if (mst_b_valid_i[idx]) begin
        pick = idx;
      end
    end
  end

  // a granted port stays granted until its handshake
  assign gnt_idx   = lock_q ? lock_idx_q : pick;
  assign b_valid_o = mst_b_valid_i[gnt_idx];
  assign b_hs      = b_valid_o & b_ready_i;

  always_comb begin
    mst_b_ready_o          = '0;
    mst_b_ready_o[gnt_idx] = b_hs;
  end

  // payload of the winner, zero while idle
  assign b_id_o   = b_valid_o ? mst_b_id_i[gnt_idx] : '0;
  assign b_resp_o = b_valid_o ? mst_b_resp_i[gnt_idx] : '0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lock_q <= 1'b0;
      prio_q <= '0;
    end else if (b_hs) begin
      lock_q <= 1'b0;
      // next search starts just past the winner
      prio_q <= gnt_idx + port_sel_t'(1);
    end else if (b_valid_o) begin
      lock_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (b_valid_o && !lock_q) begin
      lock_idx_q <= pick;
    end
  end

endmodule

// File: verilog/w_router.sv
// W channel router
`timescale 1ns/1ps

module w_router (
  input  logic                        w_valid_i,
  input  logic                        w_last_i,
  input  axi_wr_demux_pkg::port_vec_t mst_w_ready_i,
  output logic                        w_ready_o,
  output axi_wr_demux_pkg::port_vec_t mst_w_valid_o,
  w_route_if.router                   w_rt
);

  // steer valid out and ready back for the owning port only
  always_comb begin
    mst_w_valid_o = '0;
    w_ready_o     = 1'b0;
    // no open burst and no AW this cycle, W waits
    if (w_rt.w_sel_valid) begin
      mst_w_valid_o[w_rt.w_sel] = w_valid_i;
      w_ready_o                 = mst_w_ready_i[w_rt.w_sel];
    end
  end

  // burst closes on the handshake of its last beat
  assign w_rt.w_done = w_valid_i & w_ready_o & w_last_i;

endmodule

// File: verilog/id_table.sv
// per-ID in-flight table
`timescale 1ns/1ps

module id_table (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  axi_wr_demux_pkg::port_sel_t aw_select_i,
  input  logic                        pop_i,
  input  axi_wr_demux_pkg::axi_id_t   pop_id_i,
  id_track_if.tbl                     id_trk
);
  import axi_wr_demux_pkg::*;

  localparam int unsigned NUM_IDS = 2 ** $bits(look_id_t);

  cnt_t      [NUM_IDS-1:0] cnt_q;
  port_sel_t [NUM_IDS-1:0] sel_q;
  logic      [NUM_IDS-1:0] push_en, pop_en;
  logic      [NUM_IDS-1:0] occ_vec, full_vec;
  look_id_t                pop_look;

  assign pop_look = pop_id_i[$bits(look_id_t)-1:0];

  // --------------------
  // one-hot push and pop
  // --------------------
  always_comb begin
    push_en = '0;
    pop_en  = '0;
    push_en[id_trk.lookup_id] = id_trk.push;
    pop_en[pop_look]          = pop_i;
  end

  // counts, push and pop on one ID cancel
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q <= '0;
    end else begin
      for (int i = 0; i < NUM_IDS; i++) begin
        if (push_en[i] && !pop_en[i]) begin
          cnt_q[i] <= cnt_q[i] + cnt_t'(1);
        end else if (pop_en[i] && !push_en[i]) begin
          cnt_q[i] <= cnt_q[i] - cnt_t'(1);
        end
      end
    end
  end

  // port the ID is currently heading to
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NUM_IDS; i++) begin
      if (push_en[i]) begin
        sel_q[i] <= aw_select_i;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_IDS; i++) begin
      occ_vec[i]  = |cnt_q[i];
      full_vec[i] = &cnt_q[i];
    end
  end

  // --------------------
  // lookup
  // --------------------
  assign id_trk.lookup_sel = sel_q[id_trk.lookup_id];
  assign id_trk.occupied   = occ_vec[id_trk.lookup_id];
  // any saturated ID stops all admission
  assign id_trk.full       = |full_vec;

endmodule

// File: verilog/w_open_counter.sv
// open W burst counter
`timescale 1ns/1ps

module w_open_counter (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  axi_wr_demux_pkg::port_sel_t aw_select_i,
  w_route_if.counter                  w_rt
);
  import axi_wr_demux_pkg::*;

  cnt_t      open_q;
  port_sel_t sel_q;

  // up on a new AW, down on a finished burst, both cancel
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      open_q <= '0;
    end else if (w_rt.w_push && !w_rt.w_done) begin
      open_q <= open_q + cnt_t'(1);
    end else if (w_rt.w_done && !w_rt.w_push) begin
      open_q <= open_q - cnt_t'(1);
    end
  end

  // port of the latest forwarded AW
  always_ff @(posedge clk_i) begin
    if (w_rt.w_push) begin
      sel_q <= aw_select_i;
    end
  end

  assign w_rt.w_busy = |open_q;
  assign w_rt.w_full = &open_q;

  // all open bursts share one port, so the stored select covers them
  // with nothing open the live select lets W follow its AW at once
  assign w_rt.w_sel       = w_rt.w_busy ? sel_q : aw_select_i;
  assign w_rt.w_sel_valid = w_rt.w_push | w_rt.w_busy;

endmodule

// File: verilog/aw_lock_fsm.sv
// AW admission fsm
`timescale 1ns/1ps

module aw_lock_fsm (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        aw_valid_i,
  input  axi_wr_demux_pkg::axi_id_t   aw_id_i,
  input  axi_wr_demux_pkg::port_sel_t aw_select_i,
  output logic                        aw_fwd_o,
  input  logic                        aw_hs_i,
  id_track_if.fsm                     id_trk,
  w_route_if.fsm                      w_rt
);
  import axi_wr_demux_pkg::*;

  aw_state_t state_q, state_d;
  logic      room_ok, w_port_ok, id_port_ok, admit;
  logic      push;

  // tracking uses only the low ID bits
  assign id_trk.lookup_id = aw_id_i[$bits(look_id_t)-1:0];

  // --------------------
  // admission checks
  // --------------------
  // no counter may overflow
  assign room_ok    = !id_trk.full && !w_rt.w_full;
  // W channel idle or already heading to the same port
  assign w_port_ok  = !w_rt.w_busy || (w_rt.w_sel == aw_select_i);
  // same ID must not be spread over two ports
  assign id_port_ok = !id_trk.occupied || (id_trk.lookup_sel == aw_select_i);
  assign admit      = aw_valid_i && room_ok && w_port_ok && id_port_ok;

  always_comb begin
    state_d  = state_q;
    aw_fwd_o = 1'b0;
    push     = 1'b0;
    case (state_q)
      AW_IDLE: begin
        if (admit) begin
          aw_fwd_o = 1'b1;
          // counted once, on the first forward cycle
          push     = 1'b1;
          // not taken this cycle, hold the valid
          if (!aw_hs_i) begin
            state_d = AW_LOCKED;
          end
        end
      end
      AW_LOCKED: begin
        // already counted, just wait for the handshake
        aw_fwd_o = 1'b1;
        if (aw_hs_i) begin
          state_d = AW_IDLE;
        end
      end
      default: begin
        state_d = AW_IDLE;
      end
    endcase
  end

  // same pulse feeds both the ID table and the W counter
  assign id_trk.push = push;
  assign w_rt.w_push = push;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= AW_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// File: verilog/axi_wr_demux_ifs.sv
// write demux internal interfaces
`timescale 1ns/1ps

// --------------------
// AW side ID lookup and push
// --------------------
interface id_track_if;
  import axi_wr_demux_pkg::*;

  // request side, from the AW fsm
  look_id_t  lookup_id;
  logic      push;
  // answer side, from the ID table
  port_sel_t lookup_sel;
  logic      occupied;
  logic      full;

  modport fsm (output lookup_id, output push, input lookup_sel, input occupied, input full);
  modport tbl (input lookup_id, input push, output lookup_sel, output occupied, output full);
endinterface

// --------------------
// W burst steering
// --------------------
interface w_route_if;
  import axi_wr_demux_pkg::*;

  // one pulse per newly forwarded AW
  logic      w_push;
  // port that owns the W channel right now
  port_sel_t w_sel;
  logic      w_sel_valid;
  // open burst count is nonzero / saturated
  logic      w_busy;
  logic      w_full;
  // last beat handshaken
  logic      w_done;

  modport fsm (output w_push, input w_sel, input w_busy, input w_full);
  modport counter (input w_push, input w_done,
                   output w_sel, output w_sel_valid, output w_busy, output w_full);
  modport router (input w_sel, input w_sel_valid, output w_done);
endinterface

// File: verilog/axi_wr_demux_pkg.sv
// write demux types
`include "axi_wr_demux_macros.svh"

package axi_wr_demux_pkg;

  // master port index and one-bit-per-port vector
  typedef logic [$clog2(`DEMUX_NUM_PORTS)-1:0] port_sel_t;
  typedef logic [`DEMUX_NUM_PORTS-1:0]         port_vec_t;

  // IDs, full and tracked part
  typedef logic [`DEMUX_ID_W-1:0]   axi_id_t;
  typedef logic [`DEMUX_LOOK_W-1:0] look_id_t;

  // counters and payload
  typedef logic [`DEMUX_CNT_W-1:0]  cnt_t;
  typedef logic [`DEMUX_DATA_W-1:0] data_t;
  typedef logic [1:0]               resp_t;

  // AW admission states
  typedef enum logic {AW_IDLE = 1'b0, AW_LOCKED = 1'b1} aw_state_t;

endpackage

// File: verilog/axi_wr_demux_macros.svh
// write demux sizing
`ifndef AXI_WR_DEMUX_MACROS_SVH
`define AXI_WR_DEMUX_MACROS_SVH

// number of master ports behind the demux
`define DEMUX_NUM_PORTS 4

// full AXI ID width on every channel
`define DEMUX_ID_W 4

// low ID bits that get their own in-flight counter
`define DEMUX_LOOK_W 2

// in-flight and open-burst counters, all ones means full
`define DEMUX_CNT_W 3

// W data lane
`define DEMUX_DATA_W 32

`endif
